//--- elk_ctrl.sv
/*
 * electron reset and rom loader control
 * fsm for reset, load and run, registered core reset,
 * rom write gating and tape source select
 */

`timescale 1ns/1ps
`default_nettype none

module elk_ctrl (
	input  wire logic               clk_sys,
	input  wire logic               i_rst_n,
	input  wire logic               i_menu_reset,
	input  wire logic               i_load_active,
	input  wire elk_pkg::load_req_t i_load_req,
	input  wire logic               i_adc_bit,
	input  wire logic               i_tape_src_adc,
	input  wire logic               i_cas_file_bit,
	output logic                    o_rom_we,
	output logic                    o_loading,
	output logic                    o_core_rst_n,
	output logic                    o_cassette_bit
);

	import elk_pkg::*;

	ctrl_state_t state_q;
	ctrl_state_t state_d;

	//////////////////////////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////////////////////////

	// menu reset beats loading, loading beats run
	always_comb begin
		if (i_menu_reset)
			state_d = st_reset;
		else if (i_load_active)
			state_d = st_load;
		else
			state_d = st_run;
	end

	always_ff @(posedge clk_sys) begin
		if (!i_rst_n)
			state_q <= st_reset;
		else
			state_q <= state_d;
	end

	// core held in reset until a cycle after run is reached
	always_ff @(posedge clk_sys) begin
		if (!i_rst_n)
			o_core_rst_n <= 1'b0;
		else
			o_core_rst_n <= (state_q == st_run);
	end

	//////////////////////////////////////////////////////////////////////
	// loader and tape
	//////////////////////////////////////////////////////////////////////

	assign o_loading = (state_q == st_load);

	// only rom image writes, only inside the load window
	assign o_rom_we = o_loading & i_load_req.wr
		& (i_load_req.index == ROM_IMAGE_INDEX);

	// adc slicer or external tape player
	assign o_cassette_bit = i_tape_src_adc ? i_adc_bit : i_cas_file_bit;

endmodule

`default_nettype wire

//--- elk_mem_map.sv
/*
 * electron external memory map
 * decodes core address bits 18..14 into rom and sideways ram banks,
 * muxes the loader onto the rom and returns zero for void banks
 */

`timescale 1ns/1ps
`default_nettype none

module elk_mem_map (
	input  wire logic              clk_sys,
	input  wire logic              i_rst_n,
	input  wire elk_pkg::mem_req_t i_mem_req,
	input  wire logic              i_loading,
	input  wire logic              i_rom_we,
	input  wire elk_pkg::load_req_t i_load_req,
	output elk_pkg::byte_t         o_core_dout
);

	import elk_pkg::*;

	bank_code_t code;
	bank_ofs_t  ofs;
	phys_bank_t rom_bank;
	logic       rom_valid;
	logic       ram_valid;
	mem_addr_t  rom_addr;
	mem_addr_t  ram_addr;
	logic       ram_we;
	logic       we_n_q;
	logic       rom_valid_q;
	logic       ram_valid_q;
	byte_t      rom_q;
	byte_t      ram_q;

	assign code = i_mem_req.addr[CORE_AW-1:OFS_W];
	assign ofs  = i_mem_req.addr[OFS_W-1:0];

	//////////////////////////////////////////////////////////////////////
	// rom bank table
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		rom_bank  = '0;
		rom_valid = 1'b1;
		case (code)
			// filing system rom
			5'b0_01_00: rom_bank = 3'd0;
			// os, mirrored over two codes
			5'b0_10_00,
			5'b0_10_01: rom_bank = 3'd1;
			// basic, mirrored over two codes
			5'b0_10_10,
			5'b0_10_11: rom_bank = 3'd2;
			5'b0_11_00: rom_bank = 3'd3;
			// spare banks
			5'b0_11_01: rom_bank = 3'd4;
			5'b0_11_10: rom_bank = 3'd5;
			5'b0_11_11: rom_bank = 3'd6;
			// 0_00_xx and rest of 0_01_xx unmapped
			default:    rom_valid = 1'b0;
		endcase
	end

	// sideways ram lives at 1_0x_xx, low 3 bits pick the bank
	assign ram_valid = (code[4:3] == 2'b10);

	// loader owns the rom address while loading
	assign rom_addr = i_loading ? i_load_req.addr : {rom_bank, ofs};
	assign ram_addr = {code[2:0], ofs};

	// write on the high to low step of the strobe only
	assign ram_we = ram_valid & we_n_q & ~i_mem_req.we_n;

	//////////////////////////////////////////////////////////////////////
	// strobe history and read select flags
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!i_rst_n) begin
			we_n_q      <= 1'b1;
			rom_valid_q <= 1'b0;
			ram_valid_q <= 1'b0;
		end else begin
			we_n_q      <= i_mem_req.we_n;
			// flags line up with the registered memory read
			rom_valid_q <= rom_valid;
			ram_valid_q <= ram_valid;
		end
	end

	// void banks read as zero
	always_comb begin
		if (ram_valid_q)
			o_core_dout = ram_q;
		else if (rom_valid_q)
			o_core_dout = rom_q;
		else
			o_core_dout = '0;
	end

	//////////////////////////////////////////////////////////////////////
	// memories
	//////////////////////////////////////////////////////////////////////

	elk_spram #(
		.WORDS (ROM_WORDS),
		.AW    (MEM_AW)
	) u_rom (
		.clk_sys (clk_sys),
		.i_addr  (rom_addr),
		.i_data  (i_load_req.data),
		.i_we    (i_rom_we),
		.o_q     (rom_q)
	);

	elk_spram #(
		.WORDS (RAM_WORDS),
		.AW    (MEM_AW)
	) u_ram (
		.clk_sys (clk_sys),
		.i_addr  (ram_addr),
		.i_data  (i_mem_req.data),
		.i_we    (ram_we),
		.o_q     (ram_q)
	);

endmodule

`default_nettype wire

//--- elk_pkg.sv
/*
 * electron memory side definitions
 * core bus and loader types, memory map sizes, control states
 */

`default_nettype none

package elk_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths and sizes
	//////////////////////////////////////////////////////////////////////

	// core external bus is 19 bits, memories are 17 bits
	localparam int CORE_AW = 19;
	localparam int MEM_AW  = 17;
	// 16 KB bank
	localparam int OFS_W   = 14;

	// rom image holds 7 physical banks
	localparam int ROM_WORDS = 114688;
	// sideways ram holds 8 banks
	localparam int RAM_WORDS = 131072;

	//////////////////////////////////////////////////////////////////////
	// plain vector types
	//////////////////////////////////////////////////////////////////////

	typedef logic [7:0]         byte_t;
	typedef logic [7:0]         image_idx_t;
	typedef logic [CORE_AW-1:0] core_addr_t;
	typedef logic [MEM_AW-1:0]  mem_addr_t;
	typedef logic [OFS_W-1:0]   bank_ofs_t;
	// top address bits 18..14 of the core bus
	typedef logic [CORE_AW-OFS_W-1:0] bank_code_t;
	// physical bank inside either memory
	typedef logic [MEM_AW-OFS_W-1:0]  phys_bank_t;

	// download index that carries the rom image
	localparam image_idx_t ROM_IMAGE_INDEX = 8'd0;

	//////////////////////////////////////////////////////////////////////
	// bundles
	//////////////////////////////////////////////////////////////////////

	// core side memory request
	typedef struct packed {
		core_addr_t addr;
		logic       we_n;
		byte_t      data;
	} mem_req_t;

	// download port write
	typedef struct packed {
		logic       wr;
		image_idx_t index;
		mem_addr_t  addr;
		byte_t      data;
	} load_req_t;

	// reset and loader control
	typedef enum logic [1:0] {
		st_reset,
		st_load,
		st_run
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- elk_spram.sv
/*
 * single-port byte ram
 * synchronous write, registered read
 * read during write gives the new byte
 */

`timescale 1ns/1ps
`default_nettype none

module elk_spram #(
	parameter int WORDS = 1024,
	parameter int AW    = 10
) (
	input  wire logic           clk_sys,
	input  wire logic [AW-1:0]  i_addr,
	input  wire elk_pkg::byte_t i_data,
	input  wire logic           i_we,
	output elk_pkg::byte_t      o_q
);

	import elk_pkg::*;

	// storage array
	byte_t mem [WORDS];

	// one port, write wins
	always_ff @(posedge clk_sys) begin
		if (i_we) begin
			mem[i_addr] <= i_data;
			// new data through on write
			o_q <= i_data;
		end else begin
			o_q <= mem[i_addr];
		end
	end

endmodule

`default_nettype wire

//--- elk_sys_top.sv
/*
 * electron system wrapper top
 * control fsm, memory map and cassette adc slicer
 */

`timescale 1ns/1ps
`default_nettype none

module elk_sys_top (
	input  wire logic                  clk_sys,
	input  wire logic                  i_rst_n,
	input  wire logic                  i_menu_reset,
	input  wire elk_pkg::mem_req_t     i_mem_req,
	output elk_pkg::byte_t             o_core_dout,
	input  wire logic                  i_load_active,
	input  wire elk_pkg::load_req_t    i_load_req,
	input  wire tape_pkg::adc_sample_t i_adc_sample,
	input  wire logic                  i_adc_sync,
	input  wire logic                  i_tape_src_adc,
	input  wire logic                  i_cas_file_bit,
	output logic                       o_cassette_bit,
	output logic                       o_core_rst_n
);

	// ctrl to memory map
	logic rom_we;
	logic loading;
	// slicer to tape select
	logic adc_bit;

	//////////////////////////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////////////////////////

	elk_ctrl u_ctrl (
		.clk_sys        (clk_sys),
		.i_rst_n        (i_rst_n),
		.i_menu_reset   (i_menu_reset),
		.i_load_active  (i_load_active),
		.i_load_req     (i_load_req),
		.i_adc_bit      (adc_bit),
		.i_tape_src_adc (i_tape_src_adc),
		.i_cas_file_bit (i_cas_file_bit),
		.o_rom_we       (rom_we),
		.o_loading      (loading),
		.o_core_rst_n   (o_core_rst_n),
		.o_cassette_bit (o_cassette_bit)
	);

	//////////////////////////////////////////////////////////////////////
	// datapaths
	//////////////////////////////////////////////////////////////////////

	elk_mem_map u_mem_map (
		.clk_sys     (clk_sys),
		.i_rst_n     (i_rst_n),
		.i_mem_req   (i_mem_req),
		.i_loading   (loading),
		.i_rom_we    (rom_we),
		.i_load_req  (i_load_req),
		.o_core_dout (o_core_dout)
	);

	tape_adc_slicer u_slicer (
		.clk_sys      (clk_sys),
		.i_rst_n      (i_rst_n),
		.i_adc_sample (i_adc_sample),
		.i_adc_sync   (i_adc_sync),
		.o_adc_bit    (adc_bit)
	);

endmodule

`default_nettype wire

//--- list.f
elk_pkg.sv
tape_pkg.sv
elk_spram.sv
elk_mem_map.sv
tape_adc_slicer.sv
elk_ctrl.sv
elk_sys_top.sv
tb_elk_sys.sv

//--- tape_adc_slicer.sv
/*
 * cassette adc slicer
 * 512 sample running average as a high pass,
 * hysteresis comparator around it gives the tape bit
 */

`timescale 1ns/1ps
`default_nettype none

module tape_adc_slicer (
	input  wire logic                  clk_sys,
	input  wire logic                  i_rst_n,
	input  wire tape_pkg::adc_sample_t i_adc_sample,
	input  wire logic                  i_adc_sync,
	output logic                       o_adc_bit
);

	import tape_pkg::*;

	logic        sync_q;
	logic        evt;
	adc_sample_t sample_q;
	adc_sample_t avg_q;
	adc_sample_t win [AVG_DEPTH];
	adc_sum_t    total_q;
	adc_cmp_t    samp_lo;
	adc_cmp_t    samp_hi;
	adc_cmp_t    avg_lo;
	adc_cmp_t    avg_hi;

	// any toggle of sync marks a new sample
	assign evt = sync_q ^ i_adc_sync;

	// compare in 13 bits
	// sample + hyst < avg  is  sample below avg - hyst
	assign samp_lo = adc_cmp_t'(sample_q) + adc_cmp_t'(SLICE_HYST);
	assign samp_hi = adc_cmp_t'(sample_q);
	assign avg_lo  = adc_cmp_t'(avg_q);
	assign avg_hi  = adc_cmp_t'(avg_q) + adc_cmp_t'(SLICE_HYST);

	//////////////////////////////////////////////////////////////////////
	// window, total and comparator
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		// previous sync level
		sync_q <= i_adc_sync;
		if (!i_rst_n) begin
			sample_q  <= '0;
			avg_q     <= '0;
			total_q   <= '0;
			o_adc_bit <= 1'b0;
			for (int i = 0; i < AVG_DEPTH; i++)
				win[i] <= '0;
		end else if (evt) begin
			// latch new sample
			sample_q <= i_adc_sample;
			// previous sample enters the window
			win[0] <= sample_q;
			for (int i = 1; i < AVG_DEPTH; i++)
				win[i] <= win[i-1];
			// oldest drops out of the total
			total_q <= total_q - adc_sum_t'(win[AVG_DEPTH-1])
				+ adc_sum_t'(sample_q);
			// average lags the total by one event
			avg_q <= adc_sample_t'(total_q >> AVG_SHIFT);
			// low swing sets, high swing clears
			// polarity inverted against the input level
			if (samp_lo < avg_lo)
				o_adc_bit <= 1'b1;
			else if (samp_hi > avg_hi)
				o_adc_bit <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- tape_pkg.sv
/*
 * cassette input definitions
 * adc sample and running sum types, slicer constants
 */

`default_nettype none

package tape_pkg;

	// adc sample width from the converter
	localparam int ADC_W = 12;
	// sum of 512 samples of 12 bits needs 21, one spare
	localparam int SUM_W = 22;

	// running average window
	localparam int AVG_DEPTH = 512;
	localparam int AVG_SHIFT = 9;

	// comparator hysteresis in adc counts, about 0.1 V
	localparam int SLICE_HYST = 100;

	typedef logic [ADC_W-1:0] adc_sample_t;
	typedef logic [SUM_W-1:0] adc_sum_t;
	// one extra bit so the hysteresis add cannot wrap
	typedef logic [ADC_W:0]   adc_cmp_t;

endpackage

`default_nettype wire

//--- tb_elk_sys.sv
/*
 * testbench for the electron system wrapper
 * reset and load sequencing, rom map, sideways ram, adc slicer, tape select
 */

`timescale 1ns/1ps
`default_nettype none

module tb_elk_sys;

	import elk_pkg::*;
	import tape_pkg::*;

	localparam int CLK_PERIOD = 8;
	// per test cycle budgets, adc events take up to 4 cycles each
	localparam int RESET_CYCLES = 24;
	localparam int LOAD_CYCLES  = 40;
	localparam int MAP_CYCLES   = 160;
	localparam int ADC_CYCLES   = 616 * 4 + 16;
	localparam int TAPE_CYCLES  = 24;
	localparam int RUN_CYCLES   = RESET_CYCLES + LOAD_CYCLES + MAP_CYCLES
		+ ADC_CYCLES + TAPE_CYCLES;

	logic        clk_sys = 1'b0;
	logic        rst_n;
	logic        menu_reset;
	mem_req_t    mem_req;
	byte_t       core_dout;
	logic        load_active;
	load_req_t   load_req;
	adc_sample_t adc_sample;
	logic        adc_sync;
	logic        tape_src_adc;
	logic        cas_file_bit;
	logic        cassette_bit;
	logic        core_rst_n;

	// reference rom contents, one loaded byte per physical bank
	bank_ofs_t   rom_ofs [7];
	byte_t       rom_byte [7];
	// mapped rom codes and the bank each one reaches
	bank_code_t  map_code [9] = '{5'b0_01_00, 5'b0_10_00, 5'b0_10_01, 5'b0_10_10,
		5'b0_10_11, 5'b0_11_00, 5'b0_11_01, 5'b0_11_10, 5'b0_11_11};
	int unsigned map_bank [9] = '{0, 1, 1, 2, 2, 3, 4, 5, 6};
	// sideways ram reference
	core_addr_t  ram_addr [8];
	byte_t       ram_data [8];

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	elk_sys_top i_dut (
		.clk_sys        (clk_sys),
		.i_rst_n        (rst_n),
		.i_menu_reset   (menu_reset),
		.i_mem_req      (mem_req),
		.o_core_dout    (core_dout),
		.i_load_active  (load_active),
		.i_load_req     (load_req),
		.i_adc_sample   (adc_sample),
		.i_adc_sync     (adc_sync),
		.i_tape_src_adc (tape_src_adc),
		.i_cas_file_bit (cas_file_bit),
		.o_cassette_bit (cassette_bit),
		.o_core_rst_n   (core_rst_n)
	);

	//////////////////////////////////////////////////////////////////////
	// checkers
	//////////////////////////////////////////////////////////////////////

	task automatic report_fail(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("[FAIL] %s expected %0h actual %0h", name, exp, act);
		$display("RESULT: FAIL");
		$fatal(1, "check %s failed", name);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp)
		else report_fail(name, exp, act);
	endtask

	// state registers first, core reset one edge later
	assert property (@(posedge clk_sys)
		(!rst_n || menu_reset || load_active) |-> ##2 !core_rst_n)
	else report_fail("core_rst_hold", 0, 1);

	// file bit is a straight path when adc not selected
	assert property (@(posedge clk_sys) !tape_src_adc |-> cassette_bit == cas_file_bit)
	else report_fail("tape_file_path", $sampled(cas_file_bit), $sampled(cassette_bit));

	//////////////////////////////////////////////////////////////////////
	// stimulus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic drive_req(input core_addr_t core_addr, input logic strobe_n,
		input byte_t wdata);
		@(posedge clk_sys);
		mem_req <= '{addr: core_addr, we_n: strobe_n, data: wdata};
	endtask

	// registered read, data valid after the next edge
	task automatic read_check(input string name, input core_addr_t core_addr,
		input byte_t exp);
		drive_req(core_addr, 1'b1, 8'h00);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value(name, exp, core_dout);
	endtask

	// strobe high then low, extra low cycles carry changed data
	task automatic ram_write(input core_addr_t core_addr, input byte_t wdata,
		input int hold);
		drive_req(core_addr, 1'b1, wdata);
		drive_req(core_addr, 1'b0, wdata);
		for (int i = 0; i < hold; i++)
			drive_req(core_addr, 1'b0, ~wdata ^ byte_t'(i));
		drive_req(core_addr, 1'b1, wdata);
	endtask

	task automatic load_write(input image_idx_t idx, input mem_addr_t paddr,
		input byte_t pdata);
		@(posedge clk_sys);
		load_req <= '{wr: 1'b1, index: idx, addr: paddr, data: pdata};
		@(posedge clk_sys);
		load_req.wr <= 1'b0;
	endtask

	// one sync toggle per sample, uneven gaps
	task automatic adc_feed(input adc_sample_t value, input int count);
		repeat (count) begin
			@(posedge clk_sys);
			adc_sample <= value;
			adc_sync   <= ~adc_sync;
			repeat ($urandom_range(2, 0)) @(posedge clk_sys);
		end
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(21));
		rst_n        = 1'b0;
		menu_reset   = 1'b0;
		mem_req      = '{addr: '0, we_n: 1'b1, data: '0};
		load_active  = 1'b1;
		load_req     = '0;
		adc_sample   = '0;
		adc_sync     = 1'b0;
		tape_src_adc = 1'b1;
		cas_file_bit = 1'b0;

		repeat (8) @(posedge clk_sys);
		check_value("reset_core_rst", 0, core_rst_n);
		rst_n <= 1'b1;
		// fsm reaches load one edge after reset
		repeat (2) @(posedge clk_sys);
		for (int b = 0; b < 7; b++) begin
			rom_ofs[b]  = bank_ofs_t'($urandom);
			rom_byte[b] = byte_t'($urandom);
			load_write(ROM_IMAGE_INDEX, {phys_bank_t'(b), rom_ofs[b]}, rom_byte[b]);
		end
		// another image index must miss the rom
		load_write(8'd5, {phys_bank_t'(0), rom_ofs[0]}, ~rom_byte[0]);
		check_value("load_core_rst", 0, core_rst_n);

		@(posedge clk_sys);
		load_active <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("run_entry_rst", 0, core_rst_n);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("run_core_rst", 1, core_rst_n);

		// every mapped code, mirrors included
		for (int i = 0; i < 9; i++)
			read_check("rom_map", {map_code[i], rom_ofs[map_bank[i]]},
				rom_byte[map_bank[i]]);
		// 0_00_xx and 0_01_01..0_01_11
		for (int c = 0; c < 8; c++)
			if (c != 4)
				read_check("rom_void", {bank_code_t'(c), bank_ofs_t'($urandom)}, 8'h00);

		for (int b = 0; b < 8; b++) begin
			ram_addr[b] = {2'b10, 3'(b), bank_ofs_t'($urandom)};
			ram_data[b] = byte_t'($urandom);
			ram_write(ram_addr[b], ram_data[b], 0);
		end
		for (int b = 0; b < 8; b++)
			read_check("ram_bank", ram_addr[b], ram_data[b]);
		ram_write(ram_addr[3], 8'h5a, 4);
		read_check("ram_hold_low", ram_addr[3], 8'h5a);
		ram_write({map_code[1], rom_ofs[1]}, ~rom_byte[1], 0);
		read_check("rom_no_write", {map_code[1], rom_ofs[1]}, rom_byte[1]);
		// 1_1x_xx
		for (int c = 24; c < 32; c++)
			read_check("ram_void", {bank_code_t'(c), bank_ofs_t'($urandom)}, 8'h00);

		// menu reset puts the core back in reset
		@(posedge clk_sys);
		menu_reset <= 1'b1;
		repeat (3) @(posedge clk_sys);
		menu_reset <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("menu_core_rst", 0, core_rst_n);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("menu_run_rst", 1, core_rst_n);

		// fill the window, then swing around the 2000 average
		adc_feed(12'd2000, 600);
		check_value("adc_settle", 0, cassette_bit);
		adc_feed(12'd1850, 4);
		check_value("adc_low_swing", 1, cassette_bit);
		adc_feed(12'd2050, 8);
		check_value("adc_in_band", 1, cassette_bit);
		adc_feed(12'd2200, 4);
		check_value("adc_high_swing", 0, cassette_bit);

		@(posedge clk_sys);
		tape_src_adc <= 1'b0;
		for (int i = 0; i < 6; i++) begin
			@(posedge clk_sys);
			cas_file_bit <= i[0];
			@(negedge clk_sys);
			check_value("tape_file_bit", i[0], cassette_bit);
		end
		@(posedge clk_sys);
		tape_src_adc <= 1'b1;
		cas_file_bit <= 1'b1;
		@(negedge clk_sys);
		check_value("tape_adc_bit", 0, cassette_bit);

		$display("RESULT: PASS");
		$finish;
	end

	// twice the summed budget
	initial begin
		#(2 * RUN_CYCLES * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire
